//--- l2_cache_pkg.sv
/*
 * Shared definitions for the L2 cache slice:
 * cache geometry, request op codes, response status codes
 * and the address union that splits a line address into tag and set
 */

`default_nettype none

package l2_cache_pkg;

	// A line holds 16 bytes
	localparam int line_bytes = 16;
	localparam int line_bits = line_bytes * 8;

	// Four ways per set
	localparam int num_ways = 4;
	localparam int way_width = 2;

	// Sixteen sets
	localparam int num_sets = 16;
	localparam int set_width = 4;

	// The line address is the tag in the upper bits and the set in the lower bits
	localparam int tag_width = 12;
	localparam int addr_width = tag_width + set_width;

	// The data RAM index is the way followed by the set
	localparam int cache_index_width = way_width + set_width;

	// Request operations
	localparam logic [1:0] op_load = 2'd0;
	localparam logic [1:0] op_store = 2'd1;
	localparam logic [1:0] op_load_sync = 2'd2;
	localparam logic [1:0] op_store_sync = 2'd3;

	// Response status returned with every request
	localparam logic [1:0] status_miss = 2'd0;
	localparam logic [1:0] status_hit = 2'd1;
	localparam logic [1:0] status_fill = 2'd2;
	localparam logic [1:0] status_sync_fail = 2'd3;

	// One address word, seen either as a whole line address or split into its fields.
	// The set field sits in the low bits so neighbouring lines land in different sets
	typedef union packed
	{
		logic [addr_width-1:0] raw;
		struct packed
		{
			logic [tag_width-1:0] tag;
			logic [set_width-1:0] set;
		} line;
	} l2_addr_u;

endpackage

`default_nettype wire

//--- l2_cache_data_ram.sv
/*
 * Line storage for the L2 cache slice.
 * One entry per way and set, asynchronous read, clocked write
 */

`default_nettype none
`timescale 1ns/10ps

module l2_cache_data_ram import l2_cache_pkg::*;
(
	input wire logic clk,
	input wire logic reset,
	input wire logic write_enable,
	input wire logic [cache_index_width-1:0] write_index,
	input wire logic [line_bits-1:0] write_data,
	input wire logic [cache_index_width-1:0] read_index,
	output logic [line_bits-1:0] read_data
);

	// Indexed by {way, set}
	logic [line_bits-1:0] lines [num_ways * num_sets];

	// Contents survive reset, but no write is accepted while reset is held
	always_ff @(posedge clk)
	begin
		if (write_enable && !reset)
			lines[write_index] <= write_data;
	end

	// The read stage registers this, so the read path stays combinational
	assign read_data = lines[read_index];

endmodule

`default_nettype wire

//--- l2_cache_tag.sv
/*
 * Tag lookup stage of the L2 cache slice:
 * tag and valid arrays, four-way hit detection,
 * per-set round-robin victim counters and the tag update on a fill
 */

`default_nettype none
`timescale 1ns/10ps

module l2_cache_tag import l2_cache_pkg::*;
(
	input wire logic clk,
	input wire logic reset,

	// Request from the requester
	input wire logic req_valid,
	input wire logic [1:0] req_op,
	input wire logic [addr_width-1:0] req_address,
	input wire logic [line_bytes-1:0] req_mask,
	input wire logic [line_bits-1:0] req_data,
	input wire logic req_is_fill,
	input wire logic [line_bits-1:0] req_fill_data,

	// To the read stage
	output logic tag_valid,
	output logic [1:0] tag_op,
	output logic [addr_width-1:0] tag_address,
	output logic [line_bytes-1:0] tag_mask,
	output logic [line_bits-1:0] tag_data,
	output logic tag_is_fill,
	output logic [line_bits-1:0] tag_fill_data,
	output logic tag_cache_hit,
	output logic [way_width-1:0] tag_hit_way,
	output logic [way_width-1:0] tag_fill_way
);

	l2_addr_u req_addr;
	logic [tag_width-1:0] tag_mem [num_ways][num_sets];
	logic [num_sets-1:0] line_valid [num_ways];
	logic [way_width-1:0] victim_way [num_sets];
	logic [num_ways-1:0] way_hit;
	logic [way_width-1:0] hit_way;
	logic [way_width-1:0] fill_way;
	logic fill_now;

	assign req_addr.raw = req_address;

	// The victim for this set is whichever way its counter points at
	assign fill_way = victim_way[req_addr.line.set];
	assign fill_now = req_valid && req_is_fill;

	// Compare the request tag against every way of the set.
	// At most one way can match, so the last match found is the only one
	always_comb
	begin
		way_hit = '0;
		hit_way = '0;
		for (int w = 0; w < num_ways; w++)
		begin
			if (line_valid[w][req_addr.line.set]
				&& tag_mem[w][req_addr.line.set] == req_addr.line.tag)
			begin
				way_hit[w] = 1'b1;
				hit_way = way_width'(w);
			end
		end
	end

	// Tag storage itself is only written by fills
	always_ff @(posedge clk)
	begin
		if (fill_now)
			tag_mem[fill_way][req_addr.line.set] <= req_addr.line.tag;
	end

	// Valid bits and victim counters move together as a fill leaves this stage
	always_ff @(posedge clk, posedge reset)
	begin
		if (reset)
		begin
			for (int w = 0; w < num_ways; w++)
				line_valid[w] <= '0;
			for (int s = 0; s < num_sets; s++)
				victim_way[s] <= '0;
		end
		else if (fill_now)
		begin
			line_valid[fill_way][req_addr.line.set] <= 1'b1;
			victim_way[req_addr.line.set] <= victim_way[req_addr.line.set] + 1'b1;
		end
	end

	always_ff @(posedge clk, posedge reset)
	begin
		if (reset)
			tag_valid <= 1'b0;
		else
			tag_valid <= req_valid;
	end

	// Request payload and lookup results.
	// A fill always counts as a hit since it brings the line with it
	always_ff @(posedge clk)
	begin
		tag_op <= req_op;
		tag_address <= req_address;
		tag_mask <= req_mask;
		tag_data <= req_data;
		tag_is_fill <= req_is_fill;
		tag_fill_data <= req_fill_data;
		tag_cache_hit <= req_is_fill || (|way_hit);
		tag_hit_way <= hit_way;
		tag_fill_way <= fill_way;
	end

endmodule

`default_nettype wire

//--- l2_cache_read.sv
/*
 * Data read stage of the L2 cache slice:
 * data RAM lookup with bypass from the write stage,
 * the single link register and the store-sync decision
 */

`default_nettype none
`timescale 1ns/10ps

module l2_cache_read import l2_cache_pkg::*;
(
	input wire logic clk,
	input wire logic reset,

	// From the tag stage
	input wire logic tag_valid,
	input wire logic [1:0] tag_op,
	input wire logic [addr_width-1:0] tag_address,
	input wire logic [line_bytes-1:0] tag_mask,
	input wire logic [line_bits-1:0] tag_data,
	input wire logic tag_is_fill,
	input wire logic [line_bits-1:0] tag_fill_data,
	input wire logic tag_cache_hit,
	input wire logic [way_width-1:0] tag_hit_way,
	input wire logic [way_width-1:0] tag_fill_way,

	// Data RAM read port and the write stage's pending update
	input wire logic [line_bits-1:0] ram_read_data,
	input wire logic wr_update_enable,
	input wire logic [cache_index_width-1:0] wr_cache_write_index,
	input wire logic [line_bits-1:0] wr_update_data,
	output logic [cache_index_width-1:0] ram_read_index,

	// To the write stage
	output logic rd_valid,
	output logic [1:0] rd_op,
	output logic [addr_width-1:0] rd_address,
	output logic [line_bytes-1:0] rd_mask,
	output logic [line_bits-1:0] rd_data,
	output logic rd_is_fill,
	output logic [line_bits-1:0] rd_data_from_memory,
	output logic rd_cache_hit,
	output logic [way_width-1:0] rd_hit_l2_way,
	output logic [way_width-1:0] rd_miss_fill_l2_way,
	output logic [line_bits-1:0] rd_cache_mem_result,
	output logic rd_store_sync_success
);

	l2_addr_u tag_addr;
	logic link_valid;
	logic [addr_width-1:0] link_address;
	logic link_match;
	logic bypass;
	logic store_sync_success;
	logic store_done;

	assign tag_addr.raw = tag_address;
	assign ram_read_index = {tag_hit_way, tag_addr.line.set};

	// The write stage updates the RAM at the same edge this stage samples it.
	// Take its line directly so back-to-back requests see the new data
	assign bypass = wr_update_enable && wr_cache_write_index == ram_read_index;

	assign link_match = link_valid && link_address == tag_addr.raw;

	// A store-sync only lands while its link is intact and the line is present
	assign store_sync_success = tag_op == op_store_sync && tag_cache_hit && link_match;

	// Any store that actually updates the linked line breaks the link
	assign store_done = (tag_op == op_store && tag_cache_hit) || store_sync_success;

	always_ff @(posedge clk, posedge reset)
	begin
		if (reset)
		begin
			rd_valid <= 1'b0;
			link_valid <= 1'b0;
			link_address <= '0;
		end
		else
		begin
			rd_valid <= tag_valid;
			if (tag_valid && tag_op == op_load_sync && tag_cache_hit)
			begin
				link_valid <= 1'b1;
				link_address <= tag_addr.raw;
			end
			else if (tag_valid && store_done && link_match)
				link_valid <= 1'b0;
		end
	end

	always_ff @(posedge clk)
	begin
		rd_op <= tag_op;
		rd_address <= tag_address;
		rd_mask <= tag_mask;
		rd_data <= tag_data;
		rd_is_fill <= tag_is_fill;
		rd_data_from_memory <= tag_fill_data;
		rd_cache_hit <= tag_cache_hit;
		rd_hit_l2_way <= tag_hit_way;
		rd_miss_fill_l2_way <= tag_fill_way;
		rd_cache_mem_result <= bypass ? wr_update_data : ram_read_data;
		rd_store_sync_success <= store_sync_success;
	end

endmodule

`default_nettype wire

//--- l2_cache_write.sv
/*
 * Data write stage of the L2 cache slice:
 * store mask selection, per-byte merge of store data into the old line,
 * data RAM write enable and index, and the register toward the response stage
 */

`default_nettype none
`timescale 1ns/10ps

module l2_cache_write import l2_cache_pkg::*;
(
	input wire logic clk,
	input wire logic reset,

	// From the read stage
	input wire logic rd_valid,
	input wire logic [1:0] rd_op,
	input wire logic [addr_width-1:0] rd_address,
	input wire logic [line_bytes-1:0] rd_mask,
	input wire logic [line_bits-1:0] rd_data,
	input wire logic rd_is_fill,
	input wire logic [line_bits-1:0] rd_data_from_memory,
	input wire logic rd_cache_hit,
	input wire logic [way_width-1:0] rd_hit_l2_way,
	input wire logic [way_width-1:0] rd_miss_fill_l2_way,
	input wire logic [line_bits-1:0] rd_cache_mem_result,
	input wire logic rd_store_sync_success,

	// To the response stage
	output logic wr_valid,
	output logic [1:0] wr_op,
	output logic [addr_width-1:0] wr_address,
	output logic wr_cache_hit,
	output logic wr_is_fill,
	output logic wr_store_sync_success,
	output logic [line_bits-1:0] wr_data,

	// To the data RAM and the read stage bypass
	output logic wr_update_enable,
	output logic [cache_index_width-1:0] wr_cache_write_index,
	output logic [line_bits-1:0] wr_update_data
);

	l2_addr_u rd_addr;
	logic [line_bits-1:0] old_line;
	logic [line_bytes-1:0] store_mask;
	logic [line_bits-1:0] merged_line;

	assign rd_addr.raw = rd_address;

	// A fill starts from the line memory returned, anything else from the cache copy
	assign old_line = rd_is_fill ? rd_data_from_memory : rd_cache_mem_result;

	// Set bits select bytes from the store data. Loads carry no store data,
	// and a failed store-sync must leave the line as it was
	always_comb
	begin
		case (rd_op)
			op_store: store_mask = rd_mask;
			op_store_sync: store_mask = rd_mask & {line_bytes{rd_store_sync_success}};
			default: store_mask = '0;
		endcase
	end

	// One two-way mux per byte lane
	for (genvar b = 0; b < line_bytes; b++)
	begin : byte_merge
		assign merged_line[b * 8 +: 8] = store_mask[b] ? rd_data[b * 8 +: 8]
			: old_line[b * 8 +: 8];
	end

	assign wr_update_data = merged_line;

	// A fill always installs its line; stores only touch lines already present
	assign wr_update_enable = rd_valid && (rd_is_fill
		|| ((rd_op == op_store || rd_op == op_store_sync) && rd_cache_hit));

	// Fills go to the victim way picked in the tag stage
	assign wr_cache_write_index = rd_is_fill ? {rd_miss_fill_l2_way, rd_addr.line.set}
		: {rd_hit_l2_way, rd_addr.line.set};

	always_ff @(posedge clk, posedge reset)
	begin
		if (reset)
			wr_valid <= 1'b0;
		else
			wr_valid <= rd_valid;
	end

	always_ff @(posedge clk)
	begin
		wr_op <= rd_op;
		wr_address <= rd_address;
		wr_cache_hit <= rd_cache_hit;
		wr_is_fill <= rd_is_fill;
		wr_store_sync_success <= rd_store_sync_success;
		wr_data <= merged_line;
	end

endmodule

`default_nettype wire

//--- l2_cache_rsp.sv
/*
 * Response stage of the L2 cache slice.
 * Picks the status for each request and registers the response
 */

`default_nettype none
`timescale 1ns/10ps

module l2_cache_rsp import l2_cache_pkg::*;
(
	input wire logic clk,
	input wire logic reset,

	// From the write stage
	input wire logic wr_valid,
	input wire logic [1:0] wr_op,
	input wire logic [addr_width-1:0] wr_address,
	input wire logic wr_cache_hit,
	input wire logic wr_is_fill,
	input wire logic wr_store_sync_success,
	input wire logic [line_bits-1:0] wr_data,

	// To the requester
	output logic rsp_valid,
	output logic [1:0] rsp_op,
	output logic [addr_width-1:0] rsp_address,
	output logic [1:0] rsp_status,
	output logic [line_bits-1:0] rsp_data
);

	logic [1:0] status;

	// A failed store-sync takes priority, even when it arrived as a fill
	always_comb
	begin
		if (wr_op == op_store_sync && !wr_store_sync_success)
			status = status_sync_fail;
		else if (wr_is_fill)
			status = status_fill;
		else if (wr_cache_hit)
			status = status_hit;
		else
			status = status_miss;
	end

	always_ff @(posedge clk, posedge reset)
	begin
		if (reset)
			rsp_valid <= 1'b0;
		else
			rsp_valid <= wr_valid;
	end

	// A miss has no line to return
	always_ff @(posedge clk)
	begin
		rsp_op <= wr_op;
		rsp_address <= wr_address;
		rsp_status <= status;
		rsp_data <= wr_cache_hit ? wr_data : '0;
	end

endmodule

`default_nettype wire

//--- l2_cache.sv
/*
 * Top level of the L2 cache slice.
 * Chains the tag, read, write and response stages and the data RAM
 */

`default_nettype none
`timescale 1ns/10ps

module l2_cache import l2_cache_pkg::*;
(
	input wire logic clk,
	input wire logic reset,

	// Request, taken on every edge where req_valid is high
	input wire logic req_valid,
	input wire logic [1:0] req_op,
	input wire logic [addr_width-1:0] req_address,
	input wire logic [line_bytes-1:0] req_mask,
	input wire logic [line_bits-1:0] req_data,
	input wire logic req_is_fill,
	input wire logic [line_bits-1:0] req_fill_data,

	// Response, one per request, four cycles later
	output logic rsp_valid,
	output logic [1:0] rsp_op,
	output logic [addr_width-1:0] rsp_address,
	output logic [1:0] rsp_status,
	output logic [line_bits-1:0] rsp_data
);

	// Tag stage to read stage
	logic tag_valid;
	logic [1:0] tag_op;
	logic [addr_width-1:0] tag_address;
	logic [line_bytes-1:0] tag_mask;
	logic [line_bits-1:0] tag_data;
	logic tag_is_fill;
	logic [line_bits-1:0] tag_fill_data;
	logic tag_cache_hit;
	logic [way_width-1:0] tag_hit_way;
	logic [way_width-1:0] tag_fill_way;

	// Read stage to write stage, plus the RAM read port
	logic [cache_index_width-1:0] ram_read_index;
	logic [line_bits-1:0] ram_read_data;
	logic rd_valid;
	logic [1:0] rd_op;
	logic [addr_width-1:0] rd_address;
	logic [line_bytes-1:0] rd_mask;
	logic [line_bits-1:0] rd_data;
	logic rd_is_fill;
	logic [line_bits-1:0] rd_data_from_memory;
	logic rd_cache_hit;
	logic [way_width-1:0] rd_hit_l2_way;
	logic [way_width-1:0] rd_miss_fill_l2_way;
	logic [line_bits-1:0] rd_cache_mem_result;
	logic rd_store_sync_success;

	// Write stage to response stage, plus the RAM write port
	logic wr_valid;
	logic [1:0] wr_op;
	logic [addr_width-1:0] wr_address;
	logic wr_cache_hit;
	logic wr_is_fill;
	logic wr_store_sync_success;
	logic [line_bits-1:0] wr_data;
	logic wr_update_enable;
	logic [cache_index_width-1:0] wr_cache_write_index;
	logic [line_bits-1:0] wr_update_data;

	l2_cache_tag tag_stage (.*);

	l2_cache_read read_stage (.*);

	// The write stage drives the only write port, the read stage the only read port
	l2_cache_data_ram data_ram (
		.clk(clk),
		.reset(reset),
		.write_enable(wr_update_enable),
		.write_index(wr_cache_write_index),
		.write_data(wr_update_data),
		.read_index(ram_read_index),
		.read_data(ram_read_data)
	);

	l2_cache_write write_stage (.*);

	l2_cache_rsp rsp_stage (.*);

endmodule

`default_nettype wire

//--- l2_cache_checker.sv
/*
 * Response checker for the L2 cache testbench:
 * a queue of expected responses, the comparison on every rsp_valid,
 * one line per finished test and the closing counts
 */

`default_nettype none
`timescale 1ns/10ps

module l2_cache_checker import l2_cache_pkg::*;
(
	input wire logic clk,
	input wire logic reset,
	input wire logic rsp_valid,
	input wire logic [1:0] rsp_op,
	input wire logic [addr_width-1:0] rsp_address,
	input wire logic [1:0] rsp_status,
	input wire logic [line_bits-1:0] rsp_data,
	output int pass_count,
	output int error_count,
	output int checked_count
);

	// Expected responses in request order
	string exp_name [$];
	logic [1:0] exp_op [$];
	logic [addr_width-1:0] exp_address [$];
	logic [1:0] exp_status [$];
	logic [line_bits-1:0] exp_data [$];

	// Pushed by the stimulus loop as each request goes out
	task automatic add_expected(input string name, input logic [1:0] op,
		input logic [addr_width-1:0] address, input logic [1:0] status,
		input logic [line_bits-1:0] data);
		exp_name.push_back(name);
		exp_op.push_back(op);
		exp_address.push_back(address);
		exp_status.push_back(status);
		exp_data.push_back(data);
	endtask

	task automatic print_counts();
		$display("Results: %0d passed, %0d failed, %0d responses checked",
			pass_count, error_count, checked_count);
	endtask

	function automatic string status_name(input logic [1:0] status);
		case (status)
			status_miss: return "miss";
			status_hit: return "hit";
			status_fill: return "fill";
			default: return "sync_fail";
		endcase
	endfunction

	// The first field that differs is the one reported
	task automatic compare_response(input string name, input logic [1:0] op,
		input logic [addr_width-1:0] address, input logic [1:0] status,
		input logic [line_bits-1:0] data);
		checked_count++;
		if (rsp_status !== status)
		begin
			$display("Mismatch %s status: expected %s, actual %s", name,
				status_name(status), status_name(rsp_status));
			error_count++;
		end
		else if (rsp_data !== data)
		begin
			$display("Mismatch %s data: expected %h, actual %h", name, data, rsp_data);
			error_count++;
		end
		else if (rsp_address !== address || rsp_op !== op)
		begin
			$display("Mismatch %s op and address: expected %0d %h, actual %0d %h", name,
				op, address, rsp_op, rsp_address);
			error_count++;
		end
		else
		begin
			$display("Pass %s: %s %h", name, status_name(rsp_status), rsp_data);
			pass_count++;
		end
	endtask

	// Sampled mid-cycle, where the registered response is settled
	always @(negedge clk)
	begin
		if (reset)
		begin
			pass_count = 0;
			error_count = 0;
			checked_count = 0;
		end
		else if (rsp_valid)
		begin
			if (exp_name.size() == 0)
			begin
				$display("Unexpected response for address %h while no request was outstanding",
					rsp_address);
				error_count++;
			end
			else
				compare_response(exp_name.pop_front(), exp_op.pop_front(),
					exp_address.pop_front(), exp_status.pop_front(), exp_data.pop_front());
		end
	end

endmodule

`default_nettype wire

//--- tb_l2_cache.sv
/*
 * Testbench for the L2 cache slice:
 * clock and reset, the stimulus table with hand-written expected responses,
 * the loop that applies it, the cycle limit and the final verdict
 */

`default_nettype none
`timescale 1ns/10ps

module tb_l2_cache import l2_cache_pkg::*;
();

	localparam int num_tests = 26;
	localparam int reset_cycles = 5;
	localparam int idle_gap = 5;
	localparam int pipe_depth = 4;
	// Longest distance in cycles between two table entries
	localparam int max_spacing = idle_gap + 1;
	localparam int timeout_cycles = reset_cycles + num_tests * max_spacing + pipe_depth + 32;

	// Memory lines and the merged lines worked out byte by byte from the store data
	localparam logic [line_bits-1:0] line_a = 128'h0f0e0d0c_0b0a0908_07060504_03020100;
	localparam logic [line_bits-1:0] line_m1 = 128'h0f0e0d0c_0b0a0908_07060504_d1d1d1d1;
	localparam logic [line_bits-1:0] line_m2 = 128'h0f0e0d0c_0b0a0908_33333333_d1d1d1d1;
	localparam logic [line_bits-1:0] line_b = 128'hb0b1b2b3_b4b5b6b7_b8b9babb_bcbdbebf;
	localparam logic [line_bits-1:0] line_mb = 128'h22222222_b4b5b6b7_b8b9babb_bcbdbebf;
	localparam logic [line_bits-1:0] line_mb2 = 128'h22222222_44444444_b8b9babb_bcbdbebf;
	localparam logic [line_bits-1:0] line_t1 = 128'h1f1e1d1c_1b1a1918_17161514_13121110;
	localparam logic [line_bits-1:0] line_t2 = 128'h2f2e2d2c_2b2a2928_27262524_23222120;
	localparam logic [line_bits-1:0] line_t3 = 128'h3f3e3d3c_3b3a3938_37363534_33323130;
	localparam logic [line_bits-1:0] line_t4 = 128'h4f4e4d4c_4b4a4948_47464544_43424140;
	localparam logic [line_bits-1:0] line_t5 = 128'h5f5e5d5c_5b5a5958_57565554_53525150;

	logic clk = 1'b0;
	logic reset;
	logic req_valid;
	logic [1:0] req_op;
	logic [addr_width-1:0] req_address;
	logic [line_bytes-1:0] req_mask;
	logic [line_bits-1:0] req_data;
	logic req_is_fill;
	logic [line_bits-1:0] req_fill_data;
	logic rsp_valid;
	logic [1:0] rsp_op;
	logic [addr_width-1:0] rsp_address;
	logic [1:0] rsp_status;
	logic [line_bits-1:0] rsp_data;
	int pass_count;
	int error_count;
	int checked_count;
	int cycle_count = 0;

	// Stimulus table with one slot per entry
	string test_name [num_tests];
	logic [1:0] test_op [num_tests];
	logic [addr_width-1:0] test_address [num_tests];
	logic [line_bytes-1:0] test_mask [num_tests];
	logic [line_bits-1:0] test_data [num_tests];
	logic test_is_fill [num_tests];
	logic [line_bits-1:0] test_fill_data [num_tests];
	logic [1:0] test_status [num_tests];
	logic [line_bits-1:0] test_expected [num_tests];
	int test_gap [num_tests];
	int test_count = 0;

	l2_cache uut (
		.clk(clk),
		.reset(reset),
		.req_valid(req_valid),
		.req_op(req_op),
		.req_address(req_address),
		.req_mask(req_mask),
		.req_data(req_data),
		.req_is_fill(req_is_fill),
		.req_fill_data(req_fill_data),
		.rsp_valid(rsp_valid),
		.rsp_op(rsp_op),
		.rsp_address(rsp_address),
		.rsp_status(rsp_status),
		.rsp_data(rsp_data)
	);

	l2_cache_checker check (
		.clk(clk),
		.reset(reset),
		.rsp_valid(rsp_valid),
		.rsp_op(rsp_op),
		.rsp_address(rsp_address),
		.rsp_status(rsp_status),
		.rsp_data(rsp_data),
		.pass_count(pass_count),
		.error_count(error_count),
		.checked_count(checked_count)
	);

	always #20 clk = ~clk;

	// Ends a run that stops producing responses
	always @(posedge clk)
	begin
		cycle_count <= cycle_count + 1;
		if (cycle_count >= timeout_cycles)
		begin
			$display("Timeout after %0d cycles, only %0d of %0d responses arrived",
				cycle_count, checked_count, num_tests);
			$display("Test FAILED");
			$finish;
		end
	end

	// Gap is the number of idle cycles after the entry and zero means back-to-back
	task automatic add_test(input string name, input logic [1:0] op,
		input logic [addr_width-1:0] address, input logic [line_bytes-1:0] mask,
		input logic [line_bits-1:0] data, input logic is_fill,
		input logic [line_bits-1:0] fill_data, input logic [1:0] status,
		input logic [line_bits-1:0] expected, input int gap);
		test_name[test_count] = name;
		test_op[test_count] = op;
		test_address[test_count] = address;
		test_mask[test_count] = mask;
		test_data[test_count] = data;
		test_is_fill[test_count] = is_fill;
		test_fill_data[test_count] = fill_data;
		test_status[test_count] = status;
		test_expected[test_count] = expected;
		test_gap[test_count] = gap;
		test_count++;
	endtask

	task automatic drive_idle();
		req_valid <= 1'b0;
		req_op <= op_load;
		req_address <= '0;
		req_mask <= '0;
		req_data <= '0;
		req_is_fill <= 1'b0;
		req_fill_data <= '0;
	endtask

	task automatic drive_entry(input int i);
		req_valid <= 1'b1;
		req_op <= test_op[i];
		req_address <= test_address[i];
		req_mask <= test_mask[i];
		req_data <= test_data[i];
		req_is_fill <= test_is_fill[i];
		req_fill_data <= test_fill_data[i];
		check.add_expected(test_name[i], test_op[i], test_address[i], test_status[i],
			test_expected[i]);
	endtask

	initial
	begin
		reset <= 1'b1;
		drive_idle();

		// A load misses on an empty cache and hits again once its fill has installed the line
		add_test("load_miss_a", op_load, 16'h0011, '0, '0, 1'b0, '0, status_miss, '0, idle_gap);
		add_test("fill_a", op_load, 16'h0011, '0, '0, 1'b1, line_a, status_fill, line_a, idle_gap);
		add_test("load_hit_a", op_load, 16'h0011, '0, '0, 1'b0, '0, status_hit, line_a, idle_gap);

		// A partial store is followed right away by a load that needs the bypass
		add_test("store_hit_a", op_store, 16'h0011, 16'h000f, {16{8'hd1}}, 1'b0, '0,
			status_hit, line_m1, 0);
		add_test("load_bypass_a", op_load, 16'h0011, '0, '0, 1'b0, '0, status_hit, line_m1,
			idle_gap);

		// A missing store changes nothing until its fill merges the bytes
		add_test("store_miss_b", op_store, 16'h0022, 16'hf000, {16{8'h22}}, 1'b0, '0,
			status_miss, '0, idle_gap);
		add_test("load_miss_b", op_load, 16'h0022, '0, '0, 1'b0, '0, status_miss, '0, idle_gap);
		add_test("fill_store_b", op_store, 16'h0022, 16'hf000, {16{8'h22}}, 1'b1, line_b,
			status_fill, line_mb, idle_gap);
		add_test("load_b", op_load, 16'h0022, '0, '0, 1'b0, '0, status_hit, line_mb, idle_gap);

		// Load-sync and store-sync with the link intact
		add_test("load_sync_a", op_load_sync, 16'h0011, '0, '0, 1'b0, '0, status_hit, line_m1,
			idle_gap);
		add_test("store_sync_a", op_store_sync, 16'h0011, 16'h00f0, {16{8'h33}}, 1'b0, '0,
			status_hit, line_m2, idle_gap);
		add_test("load_a_after_sync", op_load, 16'h0011, '0, '0, 1'b0, '0, status_hit, line_m2,
			idle_gap);

		// A plain store between the pair breaks the link, so the store-sync fails
		add_test("load_sync_b", op_load_sync, 16'h0022, '0, '0, 1'b0, '0, status_hit, line_mb,
			idle_gap);
		add_test("store_break_b", op_store, 16'h0022, 16'h0f00, {16{8'h44}}, 1'b0, '0,
			status_hit, line_mb2, idle_gap);
		add_test("store_sync_b_fail", op_store_sync, 16'h0022, 16'h000f, {16{8'h55}}, 1'b0, '0,
			status_sync_fail, line_mb2, idle_gap);
		add_test("load_b_after_fail", op_load, 16'h0022, '0, '0, 1'b0, '0, status_hit, line_mb2,
			idle_gap);

		// Five tags into set 5 make the fifth fill wrap the victim counter back to the way of tag 1
		add_test("fill_set5_t1", op_load, 16'h0015, '0, '0, 1'b1, line_t1, status_fill, line_t1,
			idle_gap);
		add_test("fill_set5_t2", op_load, 16'h0025, '0, '0, 1'b1, line_t2, status_fill, line_t2,
			idle_gap);
		add_test("fill_set5_t3", op_load, 16'h0035, '0, '0, 1'b1, line_t3, status_fill, line_t3,
			idle_gap);
		add_test("fill_set5_t4", op_load, 16'h0045, '0, '0, 1'b1, line_t4, status_fill, line_t4,
			idle_gap);
		add_test("fill_set5_t5", op_load, 16'h0055, '0, '0, 1'b1, line_t5, status_fill, line_t5,
			idle_gap);
		add_test("load_evicted_t1", op_load, 16'h0015, '0, '0, 1'b0, '0, status_miss, '0, idle_gap);
		add_test("load_set5_t2", op_load, 16'h0025, '0, '0, 1'b0, '0, status_hit, line_t2, idle_gap);
		add_test("load_set5_t3", op_load, 16'h0035, '0, '0, 1'b0, '0, status_hit, line_t3, idle_gap);
		add_test("load_set5_t4", op_load, 16'h0045, '0, '0, 1'b0, '0, status_hit, line_t4, idle_gap);
		add_test("load_set5_t5", op_load, 16'h0055, '0, '0, 1'b0, '0, status_hit, line_t5, idle_gap);

		repeat (reset_cycles) @(posedge clk);
		reset <= 1'b0;

		for (int i = 0; i < test_count; i++)
		begin
			@(posedge clk);
			drive_entry(i);
			repeat (test_gap[i])
			begin
				@(posedge clk);
				drive_idle();
			end
		end
		@(posedge clk);
		drive_idle();

		// Wait until every queued response has been checked
		while (checked_count < test_count)
			@(posedge clk);
		repeat (3) @(posedge clk);

		check.print_counts();
		if (error_count == 0 && pass_count == num_tests)
			$display("Test OK");
		else
			$display("Test FAILED");
		$finish;
	end

endmodule

`default_nettype wire

//--- verilog.f
l2_cache_pkg.sv
l2_cache_data_ram.sv
l2_cache_tag.sv
l2_cache_read.sv
l2_cache_write.sv
l2_cache_rsp.sv
l2_cache.sv
l2_cache_checker.sv
tb_l2_cache.sv

//--- Makefile
# Verilator simulation of the L2 cache slice

VERILATOR ?= verilator
TOP ?= tb_l2_cache
FILELIST ?= verilog.f
BUILD_DIR ?= obj_dir
VFLAGS ?= --binary --timing -j 0
PASS_TEXT ?= Test OK

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build the testbench with Verilator and run it"
	@echo "  clean  remove the build directory"
	@echo "Variables: VERILATOR TOP FILELIST BUILD_DIR VFLAGS PASS_TEXT"

# The run passes only when the pass line shows up in the output
test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)
	./$(BUILD_DIR)/V$(TOP) | tee /dev/stderr | grep -qx "$(PASS_TEXT)"

clean:
	rm -rf $(BUILD_DIR)
